// File: verilog/muldiv_pkg.sv
/*
 * shared definitions for the multiply/divide subsystem
 * request function codes, datapath widths and the iteration count
 */

package muldiv_pkg;

  // ----------------------------------------
  // request function
  // ----------------------------------------

  // FN_MUL goes to the multiplier, both divides go to the divider
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } fn_t;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // operand width
  localparam int DATA_W = 32;

  // full result, two operand words
  localparam int RESULT_W = 64;

  // request tag, returned with the result
  localparam int TAG_W = 4;

  // ----------------------------------------
  // iteration control
  // ----------------------------------------

  // one CALC cycle per operand bit
  localparam int ITER_COUNT = 32;

  // step counter counts ITER_COUNT-1 down to 0
  localparam int CNT_W = 5;

endpackage

// File: verilog/int_mul_iterative.sv
/*
 * iterative shift-and-add multiplier, unsigned 64-bit product
 */

`timescale 1ns/1ps

module int_mul_iterative (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req_val,
  output logic                            req_rdy,
  input  logic [muldiv_pkg::TAG_W-1:0]    req_tag,
  input  logic [muldiv_pkg::DATA_W-1:0]   req_a,
  input  logic [muldiv_pkg::DATA_W-1:0]   req_b,
  output logic                            resp_val,
  input  logic                            resp_rdy,
  output logic [muldiv_pkg::TAG_W-1:0]    resp_tag,
  output logic [muldiv_pkg::RESULT_W-1:0] resp_result
);

  import muldiv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t              state;
  logic [CNT_W-1:0]    cnt;

  // multiplicand moves left, multiplier moves right
  logic [RESULT_W-1:0] mcand;
  logic [DATA_W-1:0]   mplier;
  logic [RESULT_W-1:0] product;
  logic [TAG_W-1:0]    tag_q;

  logic                accept;
  logic                deliver;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign accept   = req_val && req_rdy;
  assign deliver  = resp_val && resp_rdy;

  // control FSM and step counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= CALC;
            cnt   <= CNT_W'(ITER_COUNT - 1);
          end
        end
        CALC: begin
          if (cnt == '0) begin
            state <= DONE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        DONE: begin
          // hold the product until the arbiter takes it
          if (deliver) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // datapath, one partial product per CALC cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      mcand   <= {{(RESULT_W - DATA_W){1'b0}}, req_a};
      mplier  <= req_b;
      product <= '0;
      tag_q   <= req_tag;
    end else if (state == CALC) begin
      if (mplier[0]) begin
        product <= product + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign resp_result = product;
  assign resp_tag    = tag_q;

endmodule

// File: verilog/int_div_iterative.sv
/*
 * iterative restoring divider, signed and unsigned
 * IDLE/CALC/DONE state machine, result is remainder over quotient
 */

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req_val,
  output logic                            req_rdy,
  input  muldiv_pkg::fn_t                 req_fn,
  input  logic [muldiv_pkg::TAG_W-1:0]    req_tag,
  input  logic [muldiv_pkg::DATA_W-1:0]   req_a,
  input  logic [muldiv_pkg::DATA_W-1:0]   req_b,
  output logic                            resp_val,
  input  logic                            resp_rdy,
  output logic [muldiv_pkg::TAG_W-1:0]    resp_tag,
  output logic [muldiv_pkg::RESULT_W-1:0] resp_result
);

  import muldiv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t              state;
  logic [CNT_W-1:0]    cnt;

  // remainder in the upper half, quotient shifts in at the bottom
  logic [RESULT_W:0]   rem_quo;
  // divisor aligned with the remainder half
  logic [RESULT_W:0]   divisor;
  logic [TAG_W-1:0]    tag_q;
  logic                quo_neg;
  logic                rem_neg;

  logic                accept;
  logic                deliver;
  logic                is_signed;
  logic [DATA_W-1:0]   a_mag;
  logic [DATA_W-1:0]   b_mag;
  logic [RESULT_W:0]   shifted;
  logic [RESULT_W:0]   diff;
  logic [RESULT_W:0]   step_next;
  logic [DATA_W-1:0]   quo;
  logic [DATA_W-1:0]   rem;
  logic [DATA_W-1:0]   quo_fix;
  logic [DATA_W-1:0]   rem_fix;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // one operation at a time, so ready only while idle
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign accept   = req_val && req_rdy;
  assign deliver  = resp_val && resp_rdy;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  assign is_signed = (req_fn == FN_DIV);

  // two's complement magnitude for negative signed operands
  assign a_mag = (is_signed && req_a[DATA_W-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (is_signed && req_b[DATA_W-1]) ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------

  assign shifted = rem_quo << 1;
  assign diff    = shifted - divisor;

  // negative difference means the divisor did not fit, restore
  assign step_next = diff[RESULT_W] ? {shifted[RESULT_W:1], 1'b0}
                                    : {diff[RESULT_W:1], 1'b1};

  // control FSM and step counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= CALC;
            cnt   <= CNT_W'(ITER_COUNT - 1);
          end
        end
        CALC: begin
          // last step happens on the edge that sees zero
          if (cnt == '0) begin
            state <= DONE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        DONE: begin
          if (deliver) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    if (accept) begin
      rem_quo <= {{(DATA_W + 1){1'b0}}, a_mag};
      divisor <= {1'b0, b_mag, {DATA_W{1'b0}}};
      tag_q   <= req_tag;
      // unsigned divide never corrects
      quo_neg <= is_signed & (req_a[DATA_W-1] ^ req_b[DATA_W-1]);
      rem_neg <= is_signed & req_a[DATA_W-1];
    end else if (state == CALC) begin
      rem_quo <= step_next;
    end
  end

  // ----------------------------------------
  // sign correction and result
  // ----------------------------------------

  assign quo = rem_quo[DATA_W-1:0];
  assign rem = rem_quo[RESULT_W-1:DATA_W];

  // quotient truncates toward zero, remainder follows the dividend
  assign quo_fix = quo_neg ? (~quo + 1'b1) : quo;
  assign rem_fix = rem_neg ? (~rem + 1'b1) : rem;

  assign resp_result = {rem_fix, quo_fix};
  assign resp_tag    = tag_q;

endmodule

// File: verilog/muldiv_dispatch.sv
/*
 * request dispatcher, steers valid/ready to the unit named by the function
 */

`timescale 1ns/1ps

module muldiv_dispatch (
  input  logic            req_val,
  input  muldiv_pkg::fn_t req_fn,
  output logic            req_rdy,
  output logic            mul_req_val,
  input  logic            mul_req_rdy,
  output logic            div_req_val,
  input  logic            div_req_rdy
);

  import muldiv_pkg::*;

  // ----------------------------------------
  // function decode
  // ----------------------------------------

  // a busy target stalls the port even if the other unit is idle
  always_comb begin
    mul_req_val = 1'b0;
    div_req_val = 1'b0;
    req_rdy     = 1'b0;
    case (req_fn)
      FN_MUL: begin
        mul_req_val = req_val;
        req_rdy     = mul_req_rdy;
      end
      FN_DIV, FN_DIVU: begin
        div_req_val = req_val;
        req_rdy     = div_req_rdy;
      end
      default: begin
        // unused code is consumed and dropped so the port cannot hang
        req_rdy = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/resp_arbiter.sv
/*
 * round-robin merge of multiplier and divider responses onto one port
 */

`timescale 1ns/1ps

module resp_arbiter (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            mul_resp_val,
  output logic                            mul_resp_rdy,
  input  logic [muldiv_pkg::TAG_W-1:0]    mul_resp_tag,
  input  logic [muldiv_pkg::RESULT_W-1:0] mul_resp_result,
  input  logic                            div_resp_val,
  output logic                            div_resp_rdy,
  input  logic [muldiv_pkg::TAG_W-1:0]    div_resp_tag,
  input  logic [muldiv_pkg::RESULT_W-1:0] div_resp_result,
  output logic                            resp_val,
  input  logic                            resp_rdy,
  output logic [muldiv_pkg::TAG_W-1:0]    resp_tag,
  output logic [muldiv_pkg::RESULT_W-1:0] resp_result
);

  // high when the multiplier won the last transfer
  logic last_mul;
  // a stalled response keeps its grant
  logic hold;
  logic hold_div;
  logic grant_div;

  // ----------------------------------------
  // grant
  // ----------------------------------------

  // divider wins alone, or on a tie when the multiplier went last
  assign grant_div = hold ? hold_div
                          : (div_resp_val && (!mul_resp_val || last_mul));

  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp_tag    = grant_div ? div_resp_tag : mul_resp_tag;
  assign resp_result = grant_div ? div_resp_result : mul_resp_result;

  // the losing unit sees ready low
  assign div_resp_rdy = grant_div && resp_rdy;
  assign mul_resp_rdy = !grant_div && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_mul <= 1'b1;
      hold     <= 1'b0;
      hold_div <= 1'b0;
    end else begin
      hold     <= resp_val && !resp_rdy;
      hold_div <= grant_div;
      // round-robin pointer moves only on a completed transfer
      if (resp_val && resp_rdy) begin
        last_mul <= !grant_div;
      end
    end
  end

endmodule

// File: verilog/muldiv_top.sv
/*
 * multiply/divide subsystem top, dispatcher, both units and response arbiter
 */

`timescale 1ns/1ps

module muldiv_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req_val,
  output logic                            req_rdy,
  input  muldiv_pkg::fn_t                 req_fn,
  input  logic [muldiv_pkg::TAG_W-1:0]    req_tag,
  input  logic [muldiv_pkg::DATA_W-1:0]   req_a,
  input  logic [muldiv_pkg::DATA_W-1:0]   req_b,
  output logic                            resp_val,
  input  logic                            resp_rdy,
  output logic [muldiv_pkg::TAG_W-1:0]    resp_tag,
  output logic [muldiv_pkg::RESULT_W-1:0] resp_result
);

  import muldiv_pkg::*;

  // ----------------------------------------
  // dispatcher to units
  // ----------------------------------------
  logic                mul_req_val;
  logic                mul_req_rdy;
  logic                div_req_val;
  logic                div_req_rdy;

  // ----------------------------------------
  // units to arbiter
  // ----------------------------------------
  logic                mul_resp_val;
  logic                mul_resp_rdy;
  logic [TAG_W-1:0]    mul_resp_tag;
  logic [RESULT_W-1:0] mul_resp_result;
  logic                div_resp_val;
  logic                div_resp_rdy;
  logic [TAG_W-1:0]    div_resp_tag;
  logic [RESULT_W-1:0] div_resp_result;

  muldiv_dispatch dispatch0 (
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_rdy     (req_rdy),
    .mul_req_val (mul_req_val),
    .mul_req_rdy (mul_req_rdy),
    .div_req_val (div_req_val),
    .div_req_rdy (div_req_rdy)
  );

  // operands and tag go straight from the port to both units
  int_mul_iterative mul0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .req_tag     (req_tag),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_tag    (mul_resp_tag),
    .resp_result (mul_resp_result)
  );

  int_div_iterative div0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .req_fn      (req_fn),
    .req_tag     (req_tag),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_tag    (div_resp_tag),
    .resp_result (div_resp_result)
  );

  resp_arbiter arb0 (
    .clk             (clk),
    .reset           (reset),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_rdy    (mul_resp_rdy),
    .mul_resp_tag    (mul_resp_tag),
    .mul_resp_result (mul_resp_result),
    .div_resp_val    (div_resp_val),
    .div_resp_rdy    (div_resp_rdy),
    .div_resp_tag    (div_resp_tag),
    .div_resp_result (div_resp_result),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .resp_tag        (resp_tag),
    .resp_result     (resp_result)
  );

endmodule

// File: test/muldiv_tb.sv
/*
 * testbench for the multiply/divide subsystem, requests and expected results from a data file
 * random request gaps and response back-pressure, responses checked by tag
 */

`timescale 1ns/1ps

module muldiv_tb;

  import muldiv_pkg::*;

  localparam int          CLK_PERIOD    = 4;
  localparam int          NUM_REQ       = 16;
  localparam int          NUM_TAGS      = 1 << TAG_W;
  localparam int          REQ_TIMEOUT   = 300;
  localparam int          DRAIN_TIMEOUT = 1500;
  localparam int          QUIET_CYCLES  = 80;
  localparam logic [31:0] LFSR_SEED     = 32'd71015;
  localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

  logic                clk;
  logic                reset;
  logic                req_val;
  logic                req_rdy;
  fn_t                 req_fn;
  logic [TAG_W-1:0]    req_tag;
  logic [DATA_W-1:0]   req_a;
  logic [DATA_W-1:0]   req_b;
  logic                resp_val;
  logic                resp_rdy;
  logic [TAG_W-1:0]    resp_tag;
  logic [RESULT_W-1:0] resp_result;

  // five words per request: function, tag, a, b, expected result
  logic [RESULT_W-1:0] vec [0:5*NUM_REQ-1];

  // scoreboard indexed by tag
  logic [RESULT_W-1:0] exp_result [0:NUM_TAGS-1];
  logic                pending [0:NUM_TAGS-1];
  string               test_name [0:NUM_TAGS-1];

  logic [31:0]         lfsr;
  int                  sent;
  int                  received;
  int                  mismatches;
  int                  other_errors;
  int                  timeouts;

  muldiv_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_tag     (req_tag),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_tag    (resp_tag),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // galois form, shift right and fold the taps in on a one
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LFSR_TAPS;
    end
    return next;
  endfunction

  // one LFSR step per random bit
  task automatic draw_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  function automatic string fn_name(input fn_t fn);
    case (fn)
      FN_MUL:  return "mul";
      FN_DIV:  return "div";
      FN_DIVU: return "divu";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_idle(input string when);
    if (resp_val !== 1'b0) begin
      $display("error: resp_val is not low %s", when);
      other_errors++;
    end
    if (req_rdy !== 1'b1) begin
      $display("error: req_rdy is not high %s", when);
      other_errors++;
    end
  endtask

  // a tag without an outstanding request is a repeat or a stray response
  task automatic check_response(input logic [TAG_W-1:0] tag, input logic [RESULT_W-1:0] result);
    received++;
    if ($isunknown(tag)) begin
      $display("error: response tag is unknown");
      other_errors++;
    end else if (!pending[tag]) begin
      $display("error: response with tag %0d arrived with no request outstanding", tag);
      other_errors++;
    end else begin
      pending[tag] = 1'b0;
      if (result !== exp_result[tag]) begin
        $display("mismatch %s: expected %h actual %h", test_name[tag], exp_result[tag], result);
        mismatches++;
      end
    end
  endtask

  // ----------------------------------------
  // request side
  // ----------------------------------------

  // called away from the falling edge, so its random draw never meets the monitor's
  task automatic send_request(input int idx);
    logic             gap;
    int               waited;
    logic [TAG_W-1:0] tag;
    fn_t              fn;
    tag = vec[5*idx+1][TAG_W-1:0];
    fn  = fn_t'(vec[5*idx][1:0]);
    draw_bit(gap);
    @(negedge clk);
    if (gap) begin
      req_val = 1'b0;
      @(negedge clk);
    end
    req_val = 1'b1;
    req_fn  = fn;
    req_tag = tag;
    req_a   = vec[5*idx+2][DATA_W-1:0];
    req_b   = vec[5*idx+3][DATA_W-1:0];
    // ready is combinational from req_fn, sample it once settled
    #1;
    waited = 0;
    while (!req_rdy && waited < REQ_TIMEOUT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!req_rdy) begin
      $display("timeout: request with tag %0d was not accepted within %0d cycles",
               tag, REQ_TIMEOUT);
      timeouts++;
      req_val = 1'b0;
    end else begin
      // accept edge
      @(posedge clk);
      exp_result[tag] = vec[5*idx+4];
      test_name[tag]  = $sformatf("%s_tag%0d", fn_name(fn), tag);
      pending[tag]    = 1'b1;
      sent++;
    end
  endtask

  // ----------------------------------------
  // response side
  // ----------------------------------------

  // random resp_rdy every cycle, transfer seen from the stable outputs
  initial begin
    logic rdy;
    forever begin
      @(negedge clk);
      draw_bit(rdy);
      resp_rdy = rdy;
      #1;
      if (resp_val === 1'b1 && resp_rdy) begin
        check_response(resp_tag, resp_result);
      end
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    int waited;
    int i;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_fn       = FN_MUL;
    req_tag      = '0;
    req_a        = '0;
    req_b        = '0;
    resp_rdy     = 1'b0;
    lfsr         = LFSR_SEED;
    sent         = 0;
    received     = 0;
    mismatches   = 0;
    other_errors = 0;
    timeouts     = 0;
    for (i = 0; i < NUM_TAGS; i++) begin
      pending[i] = 1'b0;
    end
    $readmemh("test/muldiv_testdata.txt", vec);

    // two reset cycles, idle state checked in each
    repeat (2) begin
      @(negedge clk);
      check_idle("during reset");
    end
    reset = 1'b0;
    @(negedge clk);
    #1;
    check_idle("after reset");

    if ($isunknown(vec[5*NUM_REQ-1])) begin
      $display("error: data file holds fewer than %0d requests", NUM_REQ);
      other_errors++;
    end else begin
      for (i = 0; i < NUM_REQ; i++) begin
        send_request(i);
      end
      @(negedge clk);
      req_val = 1'b0;
    end

    // drain outstanding responses
    waited = 0;
    while (received < sent && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (received < sent) begin
      $display("timeout: only %0d of %0d responses arrived", received, sent);
      timeouts++;
    end

    // quiet window, a repeated response would show up here
    repeat (QUIET_CYCLES) @(negedge clk);
    for (i = 0; i < NUM_TAGS; i++) begin
      if (pending[i]) begin
        $display("error: tag %0d was never answered", i);
        other_errors++;
      end
    end
    if (received != sent) begin
      $display("error: %0d responses for %0d requests", received, sent);
      other_errors++;
    end

    $display("summary: %0d mismatches, %0d other errors, %0d timeouts, %0d of %0d responses",
             mismatches, other_errors, timeouts, received, sent);
    if (mismatches == 0 && other_errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: test/muldiv_testdata.txt
// columns: function (0 mul, 1 div, 2 divu), tag, a, b, expected 64-bit result
// divide results hold the remainder in the upper word and the quotient in the lower word
0 0 00000000 12345678 0000000000000000
1 1 00000007 00000002 0000000100000003
0 2 00000001 deadbeef 00000000deadbeef
1 3 fffffff9 00000002 fffffffffffffffd
0 4 ffffffff 00000001 00000000ffffffff
1 5 00000007 fffffffe 00000001fffffffd
0 6 ffffffff ffffffff fffffffe00000001
1 7 fffffff9 fffffffe ffffffff00000003
2 8 fffffff9 00000002 000000017ffffffc
0 9 00010000 00010000 0000000100000000
2 a 12345678 00000000 12345678ffffffff
0 b 12345678 00000010 0000000123456780
2 c 0000000a 00000003 0000000100000003
1 d ffffff9c 00000007 fffffffefffffff2
2 e ffffffff ffffffff 0000000000000001
1 f 80000000 ffffffff 0000000080000000

// File: all.f
verilog/muldiv_pkg.sv
verilog/int_mul_iterative.sv
verilog/int_div_iterative.sv
verilog/muldiv_dispatch.sv
verilog/resp_arbiter.sv
verilog/muldiv_top.sv
test/muldiv_tb.sv

// File: Bender.yml
package:
  name: muldiv

sources:
  - verilog/muldiv_pkg.sv
  - verilog/int_mul_iterative.sv
  - verilog/int_div_iterative.sv
  - verilog/muldiv_dispatch.sv
  - verilog/resp_arbiter.sv
  - verilog/muldiv_top.sv
  - target: test
    files:
      - test/muldiv_tb.sv
